// ==== logic/gomoku_pkg.sv ====
package gomoku_pkg;

	// signed scores with black as the maximiser
	localparam int SCORE_W = 32;

	localparam logic signed [SCORE_W-1:0] SCORE_WIN = 32'sd1000000;
	localparam logic signed [SCORE_W-1:0] SCORE_MAX = {1'b0, {(SCORE_W - 1){1'b1}}};
	localparam logic signed [SCORE_W-1:0] SCORE_MIN = -SCORE_MAX;	// negation stays in range

	localparam int WIN_LEN = 5;

	typedef enum logic [2:0] {
		NS_IDLE,
		NS_GEN,		// waiting on move_gen
		NS_DISPATCH,	// child strobe out
		NS_WAIT,	// child is scoring
		NS_FINISH
	} node_state_t;

	typedef enum logic [1:0] {
		GS_IDLE,
		GS_SCAN,
		GS_HOLD,	// candidate out until the next request
		GS_DONE
	} gen_state_t;

endpackage

// ==== logic/five_check.sv ====
`timescale 1ns/1ps

module five_check import gomoku_pkg::*; #(
	parameter int BOARD_N = 9,
	localparam int CELLS = BOARD_N * BOARD_N
) (
	input  logic [CELLS-1:0] i_board_black,
	input  logic [CELLS-1:0] i_board_white,
	output logic             o_black_five,
	output logic             o_white_five
);

// true if any WIN_LEN line of set bits exists in the bitmap
function automatic logic has_five(input logic [CELLS-1:0] bm);
	logic found;
	logic run;
	int dr;
	int dc;
	int er;
	int ec;
	found = 1'b0;
	for (int r = 0; r < BOARD_N; r++) begin
		for (int c = 0; c < BOARD_N; c++) begin
			// 0 row, 1 column, 2 diagonal, 3 anti-diagonal
			for (int d = 0; d < 4; d++) begin
				dr = (d == 0) ? 0 : 1;
				dc = (d == 1) ? 0 : ((d == 3) ? -1 : 1);
				er = r + dr * (WIN_LEN - 1);
				ec = c + dc * (WIN_LEN - 1);
				if (er < BOARD_N && ec >= 0 && ec < BOARD_N) begin
					run = 1'b1;
					for (int k = 0; k < WIN_LEN; k++)
						run = run & bm[(r + dr * k) * BOARD_N + c + dc * k];
					found = found | run;
				end
			end
		end
	end
	return found;
endfunction

assign o_black_five = has_five(i_board_black);
assign o_white_five = has_five(i_board_white);

endmodule

// ==== logic/move_gen.sv ====
`timescale 1ns/1ps

module move_gen import gomoku_pkg::*; #(
	parameter int BOARD_N = 9,
	localparam int CW = $clog2(BOARD_N + 1),
	localparam int CELLS = BOARD_N * BOARD_N
) (
	input  logic             i_clk,
	input  logic             i_rst_n,
	input  logic             i_start,
	input  logic             i_next,
	input  logic [CELLS-1:0] i_board_black,
	input  logic [CELLS-1:0] i_board_white,
	output logic             o_cand_valid,
	output logic [CW-1:0]    o_cand_x,		// column
	output logic [CW-1:0]    o_cand_y,		// row
	output logic             o_scan_done
);

gen_state_t state;
logic [CW-1:0] scan_x, scan_y;
logic [CW-1:0] next_x, next_y;
logic [CELLS-1:0] occupied;
logic board_empty;
logic last_cell;
logic qualifies;

assign occupied    = i_board_black | i_board_white;
assign board_empty = ~|occupied;
assign last_cell   = (scan_x == CW'(BOARD_N - 1)) && (scan_y == CW'(BOARD_N - 1));

// row-major step
assign next_x = (scan_x == CW'(BOARD_N - 1)) ? '0 : scan_x + 1'b1;
assign next_y = (scan_x == CW'(BOARD_N - 1)) ? scan_y + 1'b1 : scan_y;

always_comb begin
	int nx;
	int ny;
	logic near;
	near = 1'b0;
	for (int dy = -1; dy <= 1; dy++) begin
		for (int dx = -1; dx <= 1; dx++) begin
			nx = int'(scan_x) + dx;
			ny = int'(scan_y) + dy;
			if ((dx != 0 || dy != 0) && nx >= 0 && nx < BOARD_N && ny >= 0 && ny < BOARD_N)
				near = near | occupied[ny * BOARD_N + nx];
		end
	end
	if (board_empty)	// only the centre on an empty board
		qualifies = (scan_x == CW'(BOARD_N / 2)) && (scan_y == CW'(BOARD_N / 2));
	else
		qualifies = near & ~occupied[int'(scan_y) * BOARD_N + int'(scan_x)];
end

always_ff @(posedge i_clk or negedge i_rst_n) begin
	if (!i_rst_n) begin
		state        <= GS_IDLE;
		scan_x       <= '0;
		scan_y       <= '0;
		o_cand_valid <= 1'b0;
		o_cand_x     <= '0;
		o_cand_y     <= '0;
		o_scan_done  <= 1'b0;
	end else begin
		o_cand_valid <= 1'b0;
		o_scan_done  <= 1'b0;
		if (i_start) begin	// restart from any state
			state  <= GS_SCAN;
			scan_x <= '0;
			scan_y <= '0;
		end else begin
			case (state)
				GS_SCAN: begin
					if (qualifies) begin
						o_cand_valid <= 1'b1;
						o_cand_x     <= scan_x;
						o_cand_y     <= scan_y;
						state        <= GS_HOLD;
					end else if (last_cell) begin
						o_scan_done <= 1'b1;
						state       <= GS_DONE;
					end else begin
						scan_x <= next_x;
						scan_y <= next_y;
					end
				end
				GS_HOLD: begin
					if (i_next) begin
						if (last_cell) begin
							o_scan_done <= 1'b1;
							state       <= GS_DONE;
						end else begin
							scan_x <= next_x;
							scan_y <= next_y;
							state  <= GS_SCAN;
						end
					end
				end
				GS_DONE: state <= GS_IDLE;
				default: state <= GS_IDLE;
			endcase
		end
	end
end

endmodule

// ==== logic/search_node.sv ====
`timescale 1ns/1ps

module search_node import gomoku_pkg::*; #(
	parameter int BOARD_N = 9,
	localparam int CW = $clog2(BOARD_N + 1),
	localparam int CELLS = BOARD_N * BOARD_N
) (
	input  logic                      i_clk,
	input  logic                      i_rst_n,
	input  logic                      i_start,
	input  logic                      i_turn,		// 0 black, 1 white
	input  logic signed [SCORE_W-1:0] i_bound,
	input  logic [CELLS-1:0]          i_board_black,
	input  logic [CELLS-1:0]          i_board_white,
	input  logic                      i_black_five,
	input  logic                      i_white_five,
	input  logic                      i_cand_valid,
	input  logic [CW-1:0]             i_cand_x,
	input  logic [CW-1:0]             i_cand_y,
	input  logic                      i_scan_done,
	input  logic                      i_child_done,
	input  logic signed [SCORE_W-1:0] i_child_score,
	output logic                      o_gen_start,
	output logic                      o_gen_next,
	output logic                      o_child_start,
	output logic [CW-1:0]             o_child_x,
	output logic [CW-1:0]             o_child_y,
	output logic [CELLS-1:0]          o_child_board_black,
	output logic [CELLS-1:0]          o_child_board_white,
	output logic                      o_done,
	output logic signed [SCORE_W-1:0] o_score,
	output logic [CW-1:0]             o_best_x,
	output logic [CW-1:0]             o_best_y,
	output logic                      o_best_valid
);

localparam int IW = $clog2(CELLS);

node_state_t state;
logic signed [SCORE_W-1:0] best;
logic signed [SCORE_W-1:0] new_best;
logic [CW-1:0] best_x, best_y;
logic best_valid;
logic [IW-1:0] cand_idx;
logic [CELLS-1:0] move_bit;
logic take;
logic cut;

assign cand_idx = IW'(i_cand_y) * IW'(BOARD_N) + IW'(i_cand_x);
assign move_bit = {{(CELLS - 1){1'b0}}, 1'b1} << cand_idx;

// ties go to the later child
assign take     = !best_valid || (i_turn ? (i_child_score <= best) : (i_child_score >= best));
assign new_best = take ? i_child_score : best;
assign cut      = i_turn ? (new_best <= i_bound) : (new_best >= i_bound);

always_ff @(posedge i_clk or negedge i_rst_n) begin
	if (!i_rst_n) begin
		state         <= NS_IDLE;
		o_gen_start   <= 1'b0;
		o_gen_next    <= 1'b0;
		o_child_start <= 1'b0;
		o_done        <= 1'b0;
		o_score       <= '0;
		o_best_x      <= '0;
		o_best_y      <= '0;
		o_best_valid  <= 1'b0;
		best          <= '0;
		best_x        <= '0;
		best_y        <= '0;
		best_valid    <= 1'b0;
	end else begin
		o_gen_start   <= 1'b0;
		o_gen_next    <= 1'b0;
		o_child_start <= 1'b0;
		o_done        <= 1'b0;
		case (state)
			NS_IDLE: begin
				if (i_start) begin
					if (i_black_five || i_white_five) begin	// game already over
						o_done       <= 1'b1;
						o_score      <= i_black_five ? SCORE_WIN : -SCORE_WIN;
						o_best_valid <= 1'b0;
					end else begin
						o_gen_start <= 1'b1;
						best        <= i_turn ? SCORE_MAX : SCORE_MIN;
						best_valid  <= 1'b0;
						state       <= NS_GEN;
					end
				end
			end
			NS_GEN: begin
				if (i_cand_valid) begin
					o_child_start <= 1'b1;
					state         <= NS_DISPATCH;
				end else if (i_scan_done) begin
					state <= NS_FINISH;
				end
			end
			NS_DISPATCH: state <= NS_WAIT;
			NS_WAIT: begin
				if (i_child_done) begin
					best       <= new_best;
					best_valid <= 1'b1;
					if (take) begin
						best_x <= o_child_x;
						best_y <= o_child_y;
					end
					if (cut)	// alpha-beta
						state <= NS_FINISH;
					else begin
						o_gen_next <= 1'b1;
						state      <= NS_GEN;
					end
				end
			end
			NS_FINISH: begin
				o_done       <= 1'b1;
				o_score      <= best_valid ? best : '0;
				o_best_x     <= best_x;
				o_best_y     <= best_y;
				o_best_valid <= best_valid;
				state        <= NS_IDLE;
			end
			default: state <= NS_IDLE;
		endcase
	end
end

// board copy with the move in the mover's colour
always_ff @(posedge i_clk) begin
	if (state == NS_GEN && i_cand_valid) begin
		o_child_x           <= i_cand_x;
		o_child_y           <= i_cand_y;
		o_child_board_black <= i_turn ? i_board_black : (i_board_black | move_bit);
		o_child_board_white <= i_turn ? (i_board_white | move_bit) : i_board_white;
	end
end

endmodule

// ==== logic/gomoku_node_top.sv ====
`timescale 1ns/1ps

module gomoku_node_top import gomoku_pkg::*; #(
	parameter int BOARD_N = 9,
	localparam int CW = $clog2(BOARD_N + 1),
	localparam int CELLS = BOARD_N * BOARD_N
) (
	input  logic                      i_clk,
	input  logic                      i_rst_n,
	// parent side
	input  logic                      i_start,
	input  logic                      i_turn,
	input  logic signed [SCORE_W-1:0] i_bound,
	input  logic [CELLS-1:0]          i_board_black,
	input  logic [CELLS-1:0]          i_board_white,
	output logic                      o_done,
	output logic signed [SCORE_W-1:0] o_score,
	output logic [CW-1:0]             o_best_x,
	output logic [CW-1:0]             o_best_y,
	output logic                      o_best_valid,
	// child side
	output logic                      o_child_start,
	output logic [CW-1:0]             o_child_x,
	output logic [CW-1:0]             o_child_y,
	output logic [CELLS-1:0]          o_child_board_black,
	output logic [CELLS-1:0]          o_child_board_white,
	input  logic                      i_child_done,
	input  logic signed [SCORE_W-1:0] i_child_score
);

logic black_five, white_five;
logic gen_start, gen_next;
logic cand_valid, scan_done;
logic [CW-1:0] cand_x, cand_y;

five_check #(.BOARD_N(BOARD_N)) u_five_check (
	.i_board_black (i_board_black),
	.i_board_white (i_board_white),
	.o_black_five  (black_five),
	.o_white_five  (white_five)
);

move_gen #(.BOARD_N(BOARD_N)) u_move_gen (
	.i_clk         (i_clk),
	.i_rst_n       (i_rst_n),
	.i_start       (gen_start),
	.i_next        (gen_next),
	.i_board_black (i_board_black),
	.i_board_white (i_board_white),
	.o_cand_valid  (cand_valid),
	.o_cand_x      (cand_x),
	.o_cand_y      (cand_y),
	.o_scan_done   (scan_done)
);

search_node #(.BOARD_N(BOARD_N)) u_search_node (
	.i_clk               (i_clk),
	.i_rst_n             (i_rst_n),
	.i_start             (i_start),
	.i_turn              (i_turn),
	.i_bound             (i_bound),
	.i_board_black       (i_board_black),
	.i_board_white       (i_board_white),
	.i_black_five        (black_five),
	.i_white_five        (white_five),
	.i_cand_valid        (cand_valid),
	.i_cand_x            (cand_x),
	.i_cand_y            (cand_y),
	.i_scan_done         (scan_done),
	.i_child_done        (i_child_done),
	.i_child_score       (i_child_score),
	.o_gen_start         (gen_start),
	.o_gen_next          (gen_next),
	.o_child_start       (o_child_start),
	.o_child_x           (o_child_x),
	.o_child_y           (o_child_y),
	.o_child_board_black (o_child_board_black),
	.o_child_board_white (o_child_board_white),
	.o_done              (o_done),
	.o_score             (o_score),
	.o_best_x            (o_best_x),
	.o_best_y            (o_best_y),
	.o_best_valid        (o_best_valid)
);

endmodule

// ==== verif/search_node_chk.sv ====
`timescale 1ns/1ps

module search_node_chk import gomoku_pkg::*; #(
	parameter int BOARD_N = 9,
	localparam int CW = $clog2(BOARD_N + 1),
	localparam int CELLS = BOARD_N * BOARD_N
) (
	input logic                      i_clk, i_rst_n, i_start, i_turn,
	input logic signed [SCORE_W-1:0] i_bound, i_child_score,
	input logic [CELLS-1:0]          i_board_black, i_board_white,
	input logic                      i_child_done, o_done, o_best_valid, o_child_start,
	input logic signed [SCORE_W-1:0] o_score,
	input logic [CW-1:0]             o_best_x, o_best_y, o_child_x, o_child_y,
	input logic [CELLS-1:0]          o_child_board_black, o_child_board_white
);

// walks WIN_LEN steps from every cell in each direction and counts stones
function automatic logic five_in(input logic [CELLS-1:0] bm);
	int dx[4] = '{1, 0, 1, -1};
	int dy[4] = '{0, 1, 1, 1};
	int px;
	int py;
	int run;
	five_in = 1'b0;
	for (int y = 0; y < BOARD_N; y++)
		for (int x = 0; x < BOARD_N; x++)
			for (int d = 0; d < 4; d++) begin
				run = 0;
				for (int k = 0; k < WIN_LEN; k++) begin
					px = x + k * dx[d];
					py = y + k * dy[d];
					if (px >= 0 && px < BOARD_N && py < BOARD_N && bm[py * BOARD_N + px])
						run++;
				end
				if (run == WIN_LEN)
					five_in = 1'b1;
			end
endfunction

function automatic logic near_stone(input logic [CELLS-1:0] occ, input int x, input int y);
	near_stone = 1'b0;
	for (int py = y - 1; py <= y + 1; py++)
		for (int px = x - 1; px <= x + 1; px++)
			if (px >= 0 && px < BOARD_N && py >= 0 && py < BOARD_N && (px != x || py != y))
				near_stone = near_stone | occ[py * BOARD_N + px];
endfunction

logic [CELLS-1:0] occ, move_bit;
logic black_five, white_five, accept, legal, take, cut_now;
logic busy, win_search, waiting, have, cut_pend;
logic signed [SCORE_W-1:0] ebest, nbest;
logic [CW-1:0] ex, ey;
int child_idx;
int last_idx;
int err_count = 0;

assign occ        = i_board_black | i_board_white;
assign black_five = five_in(i_board_black);
assign white_five = five_in(i_board_white);
assign accept     = i_start && !busy;
assign child_idx  = int'(o_child_y) * BOARD_N + int'(o_child_x);
assign move_bit   = CELLS'(1) << child_idx;
assign legal      = !occ[child_idx] && ((occ == '0)
	? (o_child_x == CW'(BOARD_N / 2) && o_child_y == CW'(BOARD_N / 2))
	: near_stone(occ, int'(o_child_x), int'(o_child_y)));
assign take    = i_turn ? (i_child_score <= ebest) : (i_child_score >= ebest);
assign nbest   = take ? i_child_score : ebest;
assign cut_now = waiting && i_child_done && (i_turn ? nbest <= i_bound : nbest >= i_bound);

// reference model of the search in flight
always_ff @(posedge i_clk or negedge i_rst_n) begin
	if (!i_rst_n) begin
		busy       <= 1'b0;
		win_search <= 1'b0;
		waiting    <= 1'b0;
		have       <= 1'b0;
		cut_pend   <= 1'b0;
		last_idx   <= -1;
		ebest      <= '0;
		ex         <= '0;
		ey         <= '0;
	end else begin
		if (o_done)
			busy <= 1'b0;
		if (accept) begin
			busy       <= 1'b1;
			win_search <= black_five || white_five;
			have       <= 1'b0;
			cut_pend   <= 1'b0;
			last_idx   <= -1;
			ebest      <= i_turn ? SCORE_MAX : SCORE_MIN;
		end
		if (o_child_start) begin
			waiting  <= 1'b1;
			last_idx <= child_idx;
		end
		if (waiting && i_child_done) begin
			waiting <= 1'b0;
			have    <= 1'b1;
			ebest   <= nbest;
			if (take) begin	// later child wins ties
				ex <= o_child_x;
				ey <= o_child_y;
			end
			if (cut_now)
				cut_pend <= 1'b1;
		end
	end
end

a_reset: assert property (@(posedge i_clk) !i_rst_n |-> !o_done && !o_child_start && o_score == '0)
	else begin err_count++; $error("Fail o_score %h o_done %h in reset", o_score, o_done); end
a_done_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n) o_done |=> !o_done)
	else begin err_count++; $error("o_done held longer than one cycle"); end
a_child_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
	o_child_start |=> !o_child_start)
	else begin err_count++; $error("o_child_start held longer than one cycle"); end
a_done_owned: assert property (@(posedge i_clk) disable iff (!i_rst_n) o_done |-> busy)
	else begin err_count++; $error("o_done without an accepted start"); end
a_win: assert property (@(posedge i_clk) disable iff (!i_rst_n)
	accept && (black_five || white_five) |=> o_done && !o_best_valid && !o_child_start
	&& o_score == ($past(black_five) ? SCORE_WIN : -SCORE_WIN))
	else begin err_count++; $error("Fail o_score %h o_done %h on a won board", o_score, o_done); end
a_legal: assert property (@(posedge i_clk) disable iff (!i_rst_n) o_child_start |-> legal)
	else begin err_count++; $error("Fail o_child_x %h o_child_y %h not a candidate", o_child_x,
		o_child_y); end
a_order: assert property (@(posedge i_clk) disable iff (!i_rst_n)
	o_child_start |-> child_idx > last_idx)
	else begin err_count++; $error("Fail child_idx %h after last_idx %h", child_idx,
		last_idx); end
a_child_board: assert property (@(posedge i_clk) disable iff (!i_rst_n) o_child_start |->
	o_child_board_black == (i_turn ? i_board_black : (i_board_black | move_bit))
	&& o_child_board_white == (i_turn ? (i_board_white | move_bit) : i_board_white))
	else begin err_count++; $error("Fail o_child_board_black %h o_child_board_white %h",
		o_child_board_black, o_child_board_white); end
a_result: assert property (@(posedge i_clk) disable iff (!i_rst_n) o_done && !win_search |->
	o_best_valid == have && o_score == (have ? ebest : '0)
	&& (!have || (o_best_x == ex && o_best_y == ey)))
	else begin err_count++; $error("Fail o_score %h exp %h o_best_x %h o_best_y %h exp %h %h",
		o_score, have ? ebest : '0, o_best_x, o_best_y, ex, ey); end
a_cut_stop: assert property (@(posedge i_clk) disable iff (!i_rst_n) cut_pend |-> !o_child_start)
	else begin err_count++; $error("child started after the cut-off"); end
a_cut_done: assert property (@(posedge i_clk) disable iff (!i_rst_n) cut_now |=> ##1 o_done)
	else begin err_count++; $error("no o_done right after the cut-off"); end

endmodule

bind gomoku_node_top search_node_chk #(.BOARD_N(BOARD_N)) u_chk (
	.i_clk(i_clk), .i_rst_n(i_rst_n), .i_start(i_start), .i_turn(i_turn),
	.i_bound(i_bound), .i_child_score(i_child_score),
	.i_board_black(i_board_black), .i_board_white(i_board_white),
	.i_child_done(i_child_done), .o_done(o_done), .o_best_valid(o_best_valid),
	.o_child_start(o_child_start), .o_score(o_score),
	.o_best_x(o_best_x), .o_best_y(o_best_y), .o_child_x(o_child_x), .o_child_y(o_child_y),
	.o_child_board_black(o_child_board_black), .o_child_board_white(o_child_board_white)
);

// ==== verif/tb_top.sv ====
`timescale 1ns/1ps

module tb_top import gomoku_pkg::*; ();

localparam int BOARD_N = 9;
localparam int CW = $clog2(BOARD_N + 1);
localparam int CELLS = BOARD_N * BOARD_N;
localparam int NUM_SEARCH = 48;
localparam int LIMIT_NS = NUM_SEARCH * CELLS * 10 * 8 + 2000;	// 10 cycles a cell

logic                      i_clk;
logic                      i_rst_n;
logic                      i_start;
logic                      i_turn;
logic signed [SCORE_W-1:0] i_bound;
logic [CELLS-1:0]          i_board_black;
logic [CELLS-1:0]          i_board_white;
logic                      i_child_done;
logic signed [SCORE_W-1:0] i_child_score;
logic                      o_done;
logic signed [SCORE_W-1:0] o_score;
logic [CW-1:0]             o_best_x, o_best_y;
logic                      o_best_valid;
logic                      o_child_start;
logic [CW-1:0]             o_child_x, o_child_y;
logic [CELLS-1:0]          o_child_board_black, o_child_board_white;
logic [31:0]               lfsr;
int                        n_done;

gomoku_node_top #(.BOARD_N(BOARD_N)) uut (
	.i_clk               (i_clk),
	.i_rst_n             (i_rst_n),
	.i_start             (i_start),
	.i_turn              (i_turn),
	.i_bound             (i_bound),
	.i_board_black       (i_board_black),
	.i_board_white       (i_board_white),
	.o_done              (o_done),
	.o_score             (o_score),
	.o_best_x            (o_best_x),
	.o_best_y            (o_best_y),
	.o_best_valid        (o_best_valid),
	.o_child_start       (o_child_start),
	.o_child_x           (o_child_x),
	.o_child_y           (o_child_y),
	.o_child_board_black (o_child_board_black),
	.o_child_board_white (o_child_board_white),
	.i_child_done        (i_child_done),
	.i_child_score       (i_child_score)
);

always #4 i_clk = ~i_clk;

// fibonacci with taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic [31:0] take_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int k = 0; k < n; k++) begin
		lfsr = lfsr_next(lfsr);
		v = {v[30:0], lfsr[0]};
	end
	return v;
endfunction

// empty, sparse, full, or with a line of five
task automatic make_board(input int s);
	logic [31:0] r;
	int x0;
	i_board_black = '0;
	i_board_white = '0;
	if (s % 8 == 6) begin	// full board with runs of two at most
		for (int y = 0; y < BOARD_N; y++)
			for (int x = 0; x < BOARD_N; x++) begin
				i_board_black[y * BOARD_N + x] = (((x >> 1) + y) % 2 == 1);
				i_board_white[y * BOARD_N + x] = (((x >> 1) + y) % 2 == 0);
			end
	end else if (s % 8 != 0) begin
		for (int c = 0; c < CELLS; c++) begin
			r = take_bits(4);
			i_board_black[c] = (r == 0);
			i_board_white[c] = (r == 1);
		end
	end
	if (s % 8 == 3 || s % 8 == 7) begin	// black row on the bottom line
		x0 = int'(take_bits(2));
		for (int k = 0; k < WIN_LEN; k++) begin
			i_board_black[(BOARD_N - 1) * BOARD_N + x0 + k] = 1'b1;
			i_board_white[(BOARD_N - 1) * BOARD_N + x0 + k] = 1'b0;
		end
	end
	if (s % 8 == 5 || s % 8 == 7) begin
		x0 = int'(take_bits(2));
		for (int k = 0; k < WIN_LEN; k++) begin
			i_board_white[(x0 + k) * BOARD_N + x0 + k] = 1'b1;
			i_board_black[(x0 + k) * BOARD_N + x0 + k] = 1'b0;
		end
	end
endtask

// child evaluator with a delay of 1 to 8 cycles
always begin
	int delay;
	@(negedge i_clk);
	if (o_child_start) begin
		delay = 1 + int'(take_bits(3));
		repeat (delay) @(negedge i_clk);
		i_child_score = $signed(take_bits(9)) - 32'sd256;
		i_child_done  = 1'b1;
		if (delay == 3)
			i_start = 1'b1;	// a mid-search start that the node ignores
		@(negedge i_clk);
		i_child_done = 1'b0;
		i_start      = 1'b0;
	end
end

always @(negedge i_clk) begin
	if (uut.u_chk.err_count != 0) begin
		$display("test failed");
		$fatal(1, "an assertion in search_node_chk failed");
	end
end

initial begin
	#(LIMIT_NS);
	$display("test failed");
	$fatal(1, "timeout, the searches did not finish in time");
end

initial begin
	i_clk         = 1'b0;
	i_rst_n       = 1'b0;
	i_start       = 1'b0;
	i_turn        = 1'b0;
	i_bound       = '0;
	i_board_black = '0;
	i_board_white = '0;
	i_child_done  = 1'b0;
	i_child_score = '0;
	lfsr          = 32'hd798;
	n_done        = 0;
	repeat (10) @(posedge i_clk);
	@(negedge i_clk);
	i_rst_n = 1'b1;
	for (int s = 0; s < NUM_SEARCH; s++) begin
		@(negedge i_clk);
		make_board(s);
		i_turn  = 1'(take_bits(1));
		i_bound = $signed(take_bits(10)) - 32'sd512;
		i_start = 1'b1;
		@(negedge i_clk);
		i_start = 1'b0;
		while (!o_done)
			@(negedge i_clk);
		n_done++;
	end
	repeat (4) @(negedge i_clk);
	if (uut.u_chk.err_count == 0) begin
		$display("test passed");
		$finish;
	end else begin
		$display("test failed");
		$fatal(1, "assertion failures after %0d searches", n_done);
	end
end

endmodule

// ==== flist.f ====
logic/gomoku_pkg.sv
logic/five_check.sv
logic/move_gen.sv
logic/search_node.sv
logic/gomoku_node_top.sv
verif/search_node_chk.sv
verif/tb_top.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f flist.f -o tb_sim \
	&& ./obj_dir/tb_sim +verilator+error+limit+1000 \
	|| exit 1
